// ==== Bender.yml ====
package:
  name: cv_percussion_voice

sources:
  # packages first, then the interface and the design
  - hw/audio_pkg.sv
  - hw/codec_pkg.sv
  - hw/sample_pair_if.sv
  - hw/adc_capture.sv
  - hw/voice_engine.sv
  - hw/sample_fifo.sv
  - hw/i2s_tx.sv
  - hw/synth_top.sv

  # testbench, top module tb_synth_top
  - target: test
    files:
      - tests/tb_synth_top.sv

// ==== hw/adc_capture.sv ====
`timescale 1ns/1ps
// AD7606 capture: conv_n pulse, busy wait, serial read of channels 1 and 2 on db7
// next conversion starts only after the pair is taken, so downstream stalls slow the adc
module adc_capture import audio_pkg::*, codec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic db7,
	output logic conv_n,
	output logic rdclk,
	output logic cs_n,
	sample_pair_if.source adc_pair
);

	localparam int READ_BITS = ADC_WORDS * SAMPLE_W;	// 32
	localparam int BIT_W = $clog2(READ_BITS);
	localparam int CONV_W = $clog2(CONV_LOW_CYCLES) + 1;

	adc_state_t state;
	logic [CONV_W-1:0] conv_cnt;	// conv_n low cycles
	logic [BIT_W-1:0] bit_cnt;	// bit being read
	logic [READ_BITS-1:0] shreg;	// ch1 in the upper half
	logic sample_en;
	logic read_done;

	// the adc moves db7 on falling rdclk, taken when rdclk goes back high
	assign sample_en = (state == ST_READ) && !rdclk;
	assign read_done = (state == ST_READ) && rdclk && (bit_cnt == BIT_W'(READ_BITS - 1));

	//------------------------------------------------------------
	// control
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			conv_n <= 1'b1;
			cs_n <= 1'b1;
			rdclk <= 1'b1;
			conv_cnt <= '0;
			bit_cnt <= '0;
			adc_pair.valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					conv_n <= 1'b0;	// first conversion
					conv_cnt <= '0;
					state <= ST_CONVERT;
				end
				ST_CONVERT: begin
					conv_cnt <= conv_cnt + 1'b1;
					if (conv_cnt == CONV_W'(CONV_LOW_CYCLES - 1)) begin
						conv_n <= 1'b1;	// rising edge ends the pulse
						state <= ST_WAIT_BUSY_HI;
					end
				end
				ST_WAIT_BUSY_HI: begin
					if (busy)
						state <= ST_WAIT_BUSY_LO;
				end
				ST_WAIT_BUSY_LO: begin
					if (!busy) begin	// result ready, select and clock the first bit
						cs_n <= 1'b0;
						rdclk <= 1'b0;
						bit_cnt <= '0;
						state <= ST_READ;
					end
				end
				ST_READ: begin
					if (!rdclk) begin
						rdclk <= 1'b1;	// sample edge
					end else if (read_done) begin
						cs_n <= 1'b1;	// rdclk stays high
						adc_pair.valid <= 1'b1;
						state <= ST_HOLD;
					end else begin
						rdclk <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				ST_HOLD: begin
					if (adc_pair.ready) begin	// pair taken, start the next one
						adc_pair.valid <= 1'b0;
						conv_n <= 1'b0;
						conv_cnt <= '0;
						state <= ST_CONVERT;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// data path, msb first, channel 1 then channel 2
	always_ff @(posedge clk) begin
		if (sample_en)
			shreg <= {shreg[READ_BITS-2:0], db7};
		if (read_done) begin
			adc_pair.first <= shreg[READ_BITS-1 -: SAMPLE_W] + ADC_OFFSET;
			adc_pair.second <= shreg[SAMPLE_W-1:0];	// raw monitor channel
		end
	end

	// never start a conversion in the middle of a read
	assert property (@(posedge clk) disable iff (!rst_n) !cs_n |-> conv_n)
		else $error("adc_capture: conv_n low while cs_n is low");

endmodule

// ==== hw/audio_pkg.sv ====
// shared definitions of the audio path: sample format, voice constants, frame buffer
// imported by the capture block, the voice engine, the FIFO and the top level
package audio_pkg;

	//------------------------------------------------------------
	// sample format
	//------------------------------------------------------------
	localparam int SAMPLE_W = 16;	// every audio word
	typedef logic [SAMPLE_W-1:0] sample_t;	// unsigned sample

	localparam sample_t ADC_OFFSET = 16'h5000;	// added to raw channel 1
	localparam int GATE_BIT = 15;	// msb of offset channel 1 is the gate

	//------------------------------------------------------------
	// decay envelope
	//------------------------------------------------------------
	localparam sample_t ENV_START = 16'h7ffc;	// restart value on trigger
	localparam sample_t DECAY_STEP = 16'd3;	// per frame
	localparam sample_t DECAY_FLOOR = 16'd10;	// decay stops here

	//------------------------------------------------------------
	// supersaw
	//------------------------------------------------------------
	localparam int SAW_VOICES = 8;
	// slightly detuned ramps, spread of about 2 percent
	localparam logic [31:0] SAW_INC [SAW_VOICES] = '{
		32'd5078855, 32'd5098855, 32'd5118855, 32'd5138855,
		32'd5148855, 32'd5158855, 32'd5168855, 32'd5178855
	};
	localparam int SAW_TOP_W = 13;	// 8 x 13 bit sum fits 16 bits

	// stereo frames between voice and dac
	localparam int FIFO_DEPTH = 4;

endpackage

// ==== hw/codec_pkg.sv ====
// serial timing of the AD7606 and PCM5102 links plus the converter FSM states
// imported by adc_capture and i2s_tx
package codec_pkg;

	//------------------------------------------------------------
	// AD7606 serial read
	//------------------------------------------------------------
	localparam int ADC_WORDS = 2;	// channel 1 and channel 2 only
	localparam int CONV_LOW_CYCLES = 2;	// conv_n low pulse width

	typedef enum logic [2:0] {
		ST_IDLE,	// after reset only
		ST_CONVERT,	// conv_n pulse
		ST_WAIT_BUSY_HI,	// conversion accepted by the adc
		ST_WAIT_BUSY_LO,	// conversion running
		ST_READ,	// 32 rdclk periods, cs_n low
		ST_HOLD	// result offered downstream
	} adc_state_t;

	//------------------------------------------------------------
	// PCM5102 i2s
	//------------------------------------------------------------
	localparam int I2S_DIV = 4;	// clk per bck period
	localparam int I2S_BITS = 32;	// bck per frame, 16 left + 16 right

	typedef enum logic {
		ST_TX_IDLE,	// waits for the first frame
		ST_RUN	// free running frames
	} i2s_state_t;

endpackage

// ==== hw/i2s_tx.sv ====
`timescale 1ns/1ps
// PCM5102 i2s serializer, bck = clk / I2S_DIV, 32 bck per frame, left while lrck low
// pops one frame at each frame start, repeats the last frame if the FIFO runs dry
module i2s_tx import audio_pkg::*, codec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic not_empty,
	input sample_t head_left,
	input sample_t head_right,
	output logic pop,
	output logic bck,
	output logic lrck,
	output logic din
);

	localparam int DIV_W = $clog2(I2S_DIV);
	localparam int BIT_W = $clog2(I2S_BITS);

	i2s_state_t state;
	logic [DIV_W-1:0] div_cnt;	// position inside one bck period
	logic [BIT_W-1:0] bit_cnt;	// bit now on din
	logic [BIT_W-1:0] nxt_bit;
	logic [2*SAMPLE_W-1:0] frame;	// {left, right} being sent
	logic [2*SAMPLE_W-1:0] next_frame;
	logic tick_fall;	// bck goes low at this edge
	logic tick_rise;
	logic start;	// frame boundary

	always_comb begin
		tick_fall = (state == ST_RUN) && (div_cnt == DIV_W'(I2S_DIV - 1));
		tick_rise = (state == ST_RUN) && (div_cnt == DIV_W'(I2S_DIV / 2 - 1));
		nxt_bit = (state == ST_RUN) ? bit_cnt + 1'b1 : '0;	// wraps to 0
		if (state == ST_TX_IDLE)
			start = not_empty;	// first frame arrived
		else
			start = tick_fall && (bit_cnt == BIT_W'(I2S_BITS - 1));
		pop = start && not_empty;
		next_frame = pop ? {head_left, head_right} : frame;	// underflow repeats
	end

	//------------------------------------------------------------
	// bck, lrck and din
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_TX_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			bck <= 1'b0;
			lrck <= 1'b0;
			din <= 1'b0;
		end else begin
			if (state == ST_TX_IDLE) begin
				if (not_empty)
					state <= ST_RUN;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (tick_rise)
				bck <= 1'b1;
			if (start || tick_fall) begin	// new bit with bck falling
				bck <= 1'b0;
				bit_cnt <= nxt_bit;
				lrck <= nxt_bit[BIT_W-1];	// high for bits 16 to 31
				din <= next_frame[(I2S_BITS - 1) - nxt_bit];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			frame <= next_frame;
	end

	// the adc delivers well inside one frame, so the FIFO never runs dry
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_RUN) && start |-> not_empty)
		else $error("i2s_tx: underflow, last frame repeated");

endmodule

// ==== hw/sample_fifo.sv ====
`timescale 1ns/1ps
// small stereo frame FIFO between the voice engine and the i2s transmitter
// head shows the oldest frame, pop is a one cycle strobe, DEPTH a power of two
module sample_fifo import audio_pkg::*; #(
	parameter int DEPTH = FIFO_DEPTH
) (
	input logic clk,
	input logic rst_n,
	sample_pair_if.sink voice_pair,
	input logic pop,
	output logic not_empty,
	output sample_t head_left,
	output sample_t head_right
);

	localparam int AW = $clog2(DEPTH);

	logic [2*SAMPLE_W-1:0] mem [DEPTH];	// {left, right}
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;	// both wrap on their own
	logic [AW:0] count;	// frames stored
	logic push;
	logic do_pop;

	assign push = voice_pair.valid && voice_pair.ready;
	assign do_pop = pop && not_empty;
	assign voice_pair.ready = (count != (AW + 1)'(DEPTH));	// full stalls the voice
	assign not_empty = (count != '0);
	assign {head_left, head_right} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= {voice_pair.first, voice_pair.second};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// the dac side must check not_empty first
	assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty)
		else $error("sample_fifo: pop while empty");

endmodule

// ==== hw/sample_pair_if.sv ====
`timescale 1ns/1ps
// valid/ready link carrying two 16 bit words per transfer
// transfer on a rising clk with valid and ready high, source holds until then
interface sample_pair_if import audio_pkg::*; ();

	logic valid;	// source has a pair
	logic ready;	// sink takes it
	sample_t first;	// channel 1 or left
	sample_t second;	// channel 2 or right

	modport source (
		output valid,
		output first,
		output second,
		input ready
	);

	modport sink (
		input valid,
		input first,
		input second,
		output ready
	);

endinterface

// ==== hw/synth_top.sv ====
`timescale 1ns/1ps
// top level of the percussion voice with board pins only
// AD7606 capture -> voice engine -> frame FIFO -> PCM5102 i2s
module synth_top import audio_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ad_busy,
	input logic ad_db7,
	output logic ad_conv_n,
	output logic ad_rdclk,
	output logic ad_cs_n,
	output logic dac_bck,
	output logic dac_lrck,
	output logic dac_din
);

	sample_pair_if adc_pair ();	// ch1 + offset, raw ch2
	sample_pair_if voice_pair ();	// left, right

	logic pop;
	logic not_empty;
	sample_t head_left;
	sample_t head_right;

	adc_capture i_adc (
		.clk(clk),
		.rst_n(rst_n),
		.busy(ad_busy),
		.db7(ad_db7),
		.conv_n(ad_conv_n),
		.rdclk(ad_rdclk),
		.cs_n(ad_cs_n),
		.adc_pair(adc_pair.source)
	);

	voice_engine i_voice (
		.clk(clk),
		.rst_n(rst_n),
		.adc_pair(adc_pair.sink),
		.voice_pair(voice_pair.source)
	);

	sample_fifo #(.DEPTH(FIFO_DEPTH)) i_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.voice_pair(voice_pair.sink),
		.pop(pop),
		.not_empty(not_empty),
		.head_left(head_left),
		.head_right(head_right)
	);

	i2s_tx i_i2s (
		.clk(clk),
		.rst_n(rst_n),
		.not_empty(not_empty),
		.head_left(head_left),
		.head_right(head_right),
		.pop(pop),
		.bck(dac_bck),
		.lrck(dac_lrck),
		.din(dac_din)
	);

endmodule

// ==== hw/voice_engine.sv ====
`timescale 1ns/1ps
// percussion voice: gate edge, linear decay squared to an envelope, supersaw, vca
// three register stages, all holding together while the output is not taken
module voice_engine import audio_pkg::*; (
	input logic clk,
	input logic rst_n,
	sample_pair_if.sink adc_pair,
	sample_pair_if.source voice_pair
);

	logic adv;	// whole pipe moves this cycle
	logic gate;
	logic trig;	// gate rising edge
	logic gate_prev;	// gate of the previous item
	sample_t decay;	// linear ramp down
	sample_t saw_sum;
	logic [31:0] phase [SAW_VOICES];	// ramp accumulators

	logic s1_valid;
	logic s2_valid;
	sample_t s1_decay;
	sample_t s1_saw;
	sample_t s1_right;
	sample_t s2_env;
	sample_t s2_saw;
	sample_t s2_right;
	logic [2*SAMPLE_W-1:0] sq;	// decay squared
	logic [2*SAMPLE_W-1:0] vca;	// envelope times saw

	assign adv = !voice_pair.valid || voice_pair.ready;
	assign adc_pair.ready = adv;	// stage 1 free exactly when the pipe moves
	assign gate = adc_pair.first[GATE_BIT];
	assign trig = gate && !gate_prev;

	assign sq = s1_decay * s1_decay;
	assign vca = s2_env * s2_saw;

	// sum of the top bits of all ramps, cannot wrap at 8 x 13 bits
	always_comb begin
		saw_sum = '0;
		for (int i = 0; i < SAW_VOICES; i++)
			saw_sum = saw_sum + sample_t'(phase[i][31 -: SAW_TOP_W]);
	end

	//------------------------------------------------------------
	// voice state and stage valids
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gate_prev <= 1'b0;
			decay <= '0;	// silent until the first trigger
			for (int i = 0; i < SAW_VOICES; i++)
				phase[i] <= '0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			voice_pair.valid <= 1'b0;
		end else if (adv) begin
			s1_valid <= adc_pair.valid;
			s2_valid <= s1_valid;
			voice_pair.valid <= s2_valid;
			if (adc_pair.valid) begin	// one step per conversion
				gate_prev <= gate;
				if (trig)
					decay <= ENV_START;
				else if (decay > DECAY_FLOOR)
					decay <= decay - DECAY_STEP;
				for (int i = 0; i < SAW_VOICES; i++)
					phase[i] <= phase[i] + SAW_INC[i];	// wraps mod 2^32
			end
		end
	end

	//------------------------------------------------------------
	// pipeline data
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (adv) begin
			// stage 1, values before this item's update
			s1_decay <= decay;
			s1_saw <= saw_sum;
			s1_right <= adc_pair.second;
			// stage 2, envelope
			s2_env <= sq[2*SAMPLE_W-1 -: SAMPLE_W];
			s2_saw <= s1_saw;
			s2_right <= s1_right;
			// stage 3, vca
			voice_pair.first <= vca[2*SAMPLE_W-1 -: SAMPLE_W];
			voice_pair.second <= s2_right;	// monitor channel unchanged
		end
	end

	// a stalled frame must not change under the fifo
	assert property (@(posedge clk) disable iff (!rst_n)
		voice_pair.valid && !voice_pair.ready |=>
			voice_pair.valid && $stable(voice_pair.first) && $stable(voice_pair.second))
		else $error("voice_engine: output changed while stalled");

endmodule

// ==== sim.f ====
hw/audio_pkg.sv
hw/codec_pkg.sv
hw/sample_pair_if.sv
hw/adc_capture.sv
hw/voice_engine.sv
hw/sample_fifo.sv
hw/i2s_tx.sv
hw/synth_top.sv
tests/tb_synth_top.sv

// ==== tests/tb_synth_top.sv ====
`timescale 1ns/1ps
// testbench of the percussion voice with an AD7606 model on the adc pins
// and an I2S receiver on the dac pins
// every received frame is checked against a software model of the voice
module tb_synth_top import audio_pkg::*, codec_pkg::*; ();

	localparam int NUM_FRAMES = 11100;	// long enough for a full decay
	localparam int BUSY_CYCLES = 10;
	localparam int GATE_ON_A = 20;	// first rising edge
	localparam int GATE_OFF_A = 60;
	localparam int GATE_ON_B = 80;	// retrigger held to the end
	localparam int IDLE_TIMEOUT = 500;
	localparam int BCK_TIMEOUT = 200;
	localparam int FRAME_TIMEOUT = 3 * I2S_DIV * I2S_BITS;
	localparam int T_IDLE = 0, T_SILENT = 1, T_EDGES = 2, T_DECAY = 3;
	localparam int T_RIGHT = 4, T_FRAMING = 5, T_COUNT = 6, T_FLOOR = 7, N_TESTS = 8;

	logic clk, rst_n, ad_busy, ad_db7;
	logic ad_conv_n, ad_rdclk, ad_cs_n, dac_bck, dac_lrck, dac_din;

	integer seed;
	string test_name [N_TESTS];
	int test_checks [N_TESTS];
	int test_errors [N_TESTS];
	bit aborted;	// a wait ran out
	logic [15:0] ch1_raw [$];	// per conversion
	logic [15:0] ch2_val [$];
	logic [15:0] rx_left [$];	// per received frame
	logic [15:0] rx_right [$];
	logic [31:0] read_word;	// word the model shifts out
	int busy_left, bit_idx, reads_done, framing_errors, rx_bit;
	logic prev_conv_n, prev_rdclk, prev_cs_n, prev_bck, last_lrck;
	logic [31:0] rx_word;
	// voice model state starting at the reset values
	logic ref_gate_prev;
	logic [15:0] ref_decay;
	logic [15:0] ref_latched;	// decay used by the last frame
	logic [31:0] ref_phase [SAW_VOICES];

	synth_top i_dut (
		.clk(clk), .rst_n(rst_n), .ad_busy(ad_busy), .ad_db7(ad_db7),
		.ad_conv_n(ad_conv_n), .ad_rdclk(ad_rdclk), .ad_cs_n(ad_cs_n),
		.dac_bck(dac_bck), .dac_lrck(dac_lrck), .dac_din(dac_din)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 50 MHz
	end

	function bit gate_scheduled(input int n);
		return (n >= GATE_ON_A && n < GATE_OFF_A) || n >= GATE_ON_B;
	endfunction

	// runs one voice step per conversion and returns left of that frame
	function logic [15:0] voice_step(input logic [15:0] raw_ch1);
		logic [15:0] offset_ch1;
		logic gate;
		logic [15:0] saw;
		logic [31:0] top;
		logic [31:0] sq;
		logic [31:0] prod;
		int i;
		offset_ch1 = raw_ch1 + ADC_OFFSET;	// wraps at 16 bits
		gate = offset_ch1[GATE_BIT];
		saw = 16'd0;
		for (i = 0; i < SAW_VOICES; i++) begin
			top = ref_phase[i] >> (32 - SAW_TOP_W);
			saw = saw + top[15:0];
		end
		ref_latched = ref_decay;	// value before the update
		sq = ref_decay * ref_decay;
		prod = sq[31:16] * saw;	// envelope times saw
		if (gate && !ref_gate_prev)
			ref_decay = ENV_START;
		else if (ref_decay > DECAY_FLOOR)
			ref_decay = ref_decay - DECAY_STEP;
		ref_gate_prev = gate;
		for (i = 0; i < SAW_VOICES; i++)
			ref_phase[i] = ref_phase[i] + SAW_INC[i];
		return prod[31:16];
	endfunction

	task compare_word(input int test, input int idx, input logic [15:0] expected,
			input logic [15:0] actual);
		test_checks[test] = test_checks[test] + 1;
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s item %0d: expected %h, actual %h",
				test_name[test], idx, expected, actual);
			test_errors[test] = test_errors[test] + 1;
		end
	endtask

	task report_test(input int test);
		$display("%-16s %0d checks, %0d errors", test_name[test], test_checks[test],
			test_errors[test]);
	endtask

	task note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		aborted = 1'b1;
	endtask

	// new conversion with the scheduled gate and random low bits
	task new_conversion;
		logic [31:0] rnd;
		logic [15:0] raw;
		rnd = $random(seed);
		if (gate_scheduled(ch1_raw.size()))
			raw = 16'h3000 + (rnd[15:0] & 16'h7fff);	// offset result has bit 15 set
		else
			raw = 16'hb000 + (rnd[15:0] & 16'h7fff);	// wraps below 16'h3000
		rnd = $random(seed);
		ch1_raw.push_back(raw);
		ch2_val.push_back(rnd[15:0]);
		read_word = {raw, rnd[15:0]};
	endtask

	//------------------------------------------------------------
	// AD7606 model
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			ad_busy = 1'b0;
			busy_left = 0;
			bit_idx = 0;
			prev_conv_n = 1'b1;
			prev_rdclk = 1'b1;
			prev_cs_n = 1'b1;
		end else begin
			if (prev_conv_n && !ad_conv_n) begin	// conversion start
				new_conversion();
				ad_busy = 1'b1;
				busy_left = BUSY_CYCLES;
			end else if (busy_left != 0) begin
				busy_left = busy_left - 1;
				if (busy_left == 0)
					ad_busy = 1'b0;
			end
			if (ad_cs_n)
				bit_idx = 0;
			else if (prev_rdclk && !ad_rdclk) begin	// next bit on falling rdclk
				ad_db7 = read_word[31 - bit_idx];
				bit_idx = bit_idx + 1;
			end
			if (!prev_cs_n && ad_cs_n)
				reads_done = reads_done + 1;	// read finished
			prev_conv_n = ad_conv_n;
			prev_rdclk = ad_rdclk;
			prev_cs_n = ad_cs_n;
		end
	end

	//------------------------------------------------------------
	// I2S receiver taking din at rising bck
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_bck = 1'b0;
			last_lrck = 1'b1;	// first low lrck opens a frame
			rx_bit = 0;
		end else begin
			if (dac_bck && !prev_bck) begin
				if (!dac_lrck && last_lrck) begin	// left half starts
					if (rx_bit != 0)
						framing_errors = framing_errors + 1;
					rx_bit = 0;
				end
				if (dac_lrck != (rx_bit >= 16))
					framing_errors = framing_errors + 1;
				rx_word = {rx_word[30:0], dac_din};
				last_lrck = dac_lrck;
				if (rx_bit == I2S_BITS - 1) begin
					rx_left.push_back(rx_word[31:16]);
					rx_right.push_back(rx_word[15:0]);
					rx_bit = 0;
				end else
					rx_bit = rx_bit + 1;
			end
			prev_bck = dac_bck;
		end
	end

	// outputs stay quiet until the first conversion is read
	task automatic watch_until_first_read;
		int cyc;
		bit seen_read;
		bit done;
		seen_read = 1'b0;
		done = 1'b0;
		for (cyc = 1; cyc <= IDLE_TIMEOUT && !done; cyc++) begin
			@(negedge clk);
			compare_word(T_IDLE, cyc, 16'h0000, {13'd0, dac_bck, dac_lrck, dac_din});
			if (!ad_cs_n)
				seen_read = 1'b1;
			else if (seen_read)
				done = 1'b1;
		end
		if (!done)
			note_timeout("the first conversion");
	endtask

	task automatic wait_bck_start;
		int cyc;
		cyc = 0;
		while (dac_bck !== 1'b1 && cyc < BCK_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (dac_bck !== 1'b1)
			note_timeout("bck to start");
	endtask

	task automatic wait_frame(input int n);
		int cyc;
		cyc = 0;
		while (rx_left.size() <= n && cyc < FRAME_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (rx_left.size() <= n)
			note_timeout($sformatf("frame %0d", n));
	endtask

	task check_frame(input int n);
		logic [15:0] exp_left;
		exp_left = voice_step(ch1_raw[n]);
		compare_word(T_RIGHT, n, ch2_val[n], rx_right[n]);	// monitor passes through
		if (n < GATE_ON_A)
			compare_word(T_SILENT, n, 16'h0000, rx_left[n]);	// no trigger yet
		else if (n < 100)
			compare_word(T_EDGES, n, exp_left, rx_left[n]);
		else if (ref_latched == DECAY_FLOOR)
			compare_word(T_FLOOR, n, exp_left, rx_left[n]);	// decay held at the floor
		else
			compare_word(T_DECAY, n, exp_left, rx_left[n]);
		if (n == GATE_ON_A - 1)
			report_test(T_SILENT);
		if (n == 99)
			report_test(T_EDGES);
	endtask

	//------------------------------------------------------------
	// compare process
	//------------------------------------------------------------
	initial begin
		int n;
		int in_flight;
		int total_checks;
		int total_errors;
		test_name = '{"reset_idle", "gate_low_silence", "gate_edges", "long_decay",
			"right_channel", "i2s_framing", "frame_count", "decay_floor"};
		for (n = 0; n < N_TESTS; n++) begin
			test_checks[n] = 0;
			test_errors[n] = 0;
		end
		seed = 32'h543f_3de6;
		rst_n = 1'b0;
		ad_busy = 1'b0;
		ad_db7 = 1'b0;
		aborted = 1'b0;
		reads_done = 0;
		framing_errors = 0;
		rx_word = '0;
		read_word = '0;
		ref_gate_prev = 1'b0;
		ref_decay = '0;
		ref_latched = '0;
		for (n = 0; n < SAW_VOICES; n++)
			ref_phase[n] = '0;
		repeat (8) @(negedge clk);
		// conv_n, cs_n high, bck, lrck, din low
		compare_word(T_IDLE, 0, 16'h0018, {11'd0, ad_conv_n, ad_cs_n, dac_bck, dac_lrck, dac_din});
		rst_n = 1'b1;
		watch_until_first_read();
		report_test(T_IDLE);
		if (!aborted)
			wait_bck_start();
		for (n = 0; n < NUM_FRAMES && !aborted; n++) begin
			wait_frame(n);
			if (!aborted)
				check_frame(n);
		end
		if (!aborted) begin
			report_test(T_DECAY);
			report_test(T_RIGHT);
			compare_word(T_FRAMING, 0, 16'h0000, framing_errors[15:0]);
			report_test(T_FRAMING);
			in_flight = reads_done - rx_left.size();	// fifo, pipe and hold
			test_checks[T_COUNT] = 1;
			assert (in_flight >= 0 && in_flight <= FIFO_DEPTH + 4)
			else begin
				$display("%0d conversions finished but %0d frames received",
					reads_done, rx_left.size());
				test_errors[T_COUNT] = 1;
			end
			report_test(T_COUNT);
			report_test(T_FLOOR);
		end
		total_checks = 0;
		total_errors = 0;
		for (n = 0; n < N_TESTS; n++) begin
			total_checks = total_checks + test_checks[n];
			total_errors = total_errors + test_errors[n];
		end
		$display("%0d tests, %0d checks, %0d errors, %0d frames", N_TESTS, total_checks,
			total_errors, rx_left.size());
		if (total_errors == 0 && !aborted)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
